// ==== sim.f ====
src/cen_pkg.sv
src/cen_frac.sv
src/freq_window.sv
src/bcd_fsm.sv
src/cen_loop.sv
verif/cen_loop_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the clock enable testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module cen_loop_tb \
    -f sim.f \
    -o cen_loop_sim

./obj_dir/cen_loop_sim

// ==== verif/cen_loop_tb.sv ====
// CPU clock enable testbench
`default_nettype none
`timescale 1ns/100ps

module cen_loop_tb
    import cen_pkg::*;
();

    localparam int WIN        = 200;
    localparam int UPDATE_LAT = 31;
    localparam int SEED       = 32'ha2a9_588e;

    // Channel order main, sub, sound, MCU
    localparam frac_t CH_NUM [4] = '{10'd3, 10'd3, 10'd1, 10'd1};
    localparam frac_t CH_DEN [4] = '{10'd8, 10'd8, 10'd4, 10'd2};

    typedef struct packed {
        frac_t   acc;
        logic    prc;
        credit_t credit;
    } chan_model_t;

    // Finished window waiting for its BCD update
    typedef struct packed {
        win_count_t ave;
        win_count_t worst;
        int         last_cycle;
    } window_rec_t;

    logic       clk;
    logic       reset;
    busy_t      busy;
    logic [3:0] prc_vec;
    logic [3:0] cen_vec;
    bcd_t       fave;
    bcd_t       fworst;
    logic       update;

    chan_model_t model [4];
    window_rec_t pending [$];
    win_count_t  exp_worst;
    int          cyc_n;
    int          win_cnt;

    cen_loop #(
        .MAIN_NUM   ( CH_NUM[0] ),
        .MAIN_DEN   ( CH_DEN[0] ),
        .SUB_NUM    ( CH_NUM[1] ),
        .SUB_DEN    ( CH_DEN[1] ),
        .SND_NUM    ( CH_NUM[2] ),
        .SND_DEN    ( CH_DEN[2] ),
        .MCU_NUM    ( CH_NUM[3] ),
        .MCU_DEN    ( CH_DEN[3] ),
        .WIN_CYCLES ( WIN       )
    ) uut (
        .clk      ( clk        ),
        .reset    ( reset      ),
        .busy     ( busy       ),
        .prc_main ( prc_vec[0] ),
        .prc_sub  ( prc_vec[1] ),
        .prc_snd  ( prc_vec[2] ),
        .prc_mcu  ( prc_vec[3] ),
        .cen_main ( cen_vec[0] ),
        .cen_sub  ( cen_vec[1] ),
        .cen_snd  ( cen_vec[2] ),
        .cen_mcu  ( cen_vec[3] ),
        .fave     ( fave       ),
        .fworst   ( fworst     ),
        .update   ( update     )
    );

    // Advance one channel by a cycle and return its expected outputs
    function automatic chan_model_t channel_step(input chan_model_t s, input frac_t num,
                                                 input frac_t den, input logic stall,
                                                 output logic exp_prc, output logic exp_cen);
        chan_model_t n;
        int          sum;
        exp_prc = s.prc;
        exp_cen = !stall && (s.prc || s.credit != 0);
        n       = s;
        sum     = int'(s.acc) + int'(num);
        n.prc   = sum >= int'(den);
        if (n.prc) begin
            sum = sum - int'(den);
        end
        n.acc = frac_t'(sum);
        if (stall) begin
            // Due enable is banked while the bus is held
            if (s.prc && s.credit != CREDIT_MAX) begin
                n.credit = s.credit + 1'b1;
            end
        end else if (!s.prc && s.credit != 0) begin
            n.credit = s.credit - 1'b1;
        end
        return n;
    endfunction

    // Decimal digits by division
    function automatic bcd_t to_bcd(input win_count_t v);
        bcd_t r;
        int   n;
        int   i;
        n = int'(v);
        for (i = 0; i < 4; i++) begin
            r[i*4 +: 4] = 4'(n % 10);
            n = n / 10;
        end
        return r;
    endfunction

    function automatic string chan_name(input int i);
        case (i)
            0: return "main";
            1: return "sub";
            2: return "snd";
            default: return "mcu";
        endcase
    endfunction

    task automatic stop_run();
        $display("Test FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s = %b, expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_bcd(input string name, input bcd_t got, input bcd_t exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_count(input string name, input win_count_t got, input win_count_t exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_latency(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("Fail at %0t ns: %s latency = %0d, expected %0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic wait_update();
        int i;
        bit seen;
        seen = 1'b0;
        for (i = 0; i < 400 && !seen; i++) begin
            @(negedge clk);
            seen = update;
        end
        if (!seen) begin
            $display("No update pulse arrived within 400 cycles");
            stop_run();
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Cycle by cycle comparison sampled mid cycle
    always @(negedge clk) begin
        int          i;
        logic        exp_prc;
        logic        exp_cen;
        window_rec_t done_rec;
        window_rec_t head;
        if (reset) begin
            for (i = 0; i < 4; i++) begin
                model[i] = '0;
            end
            pending.delete();
            exp_worst = win_count_t'(9999);
            cyc_n     = 0;
            win_cnt   = 0;
        end else begin
            if (busy != '0 && cen_vec != 4'b0000) begin
                $display("Clock enable high at %0t ns while busy is %b", $time, busy);
                stop_run();
            end
            for (i = 0; i < 4; i++) begin
                model[i] = channel_step(model[i], CH_NUM[i], CH_DEN[i], busy != '0,
                                        exp_prc, exp_cen);
                check_bit({"prc_", chan_name(i)}, prc_vec[i], exp_prc);
                check_bit({"cen_", chan_name(i)}, cen_vec[i], exp_cen);
            end
            if (cen_vec[0]) begin
                win_cnt++;
            end
            if (cyc_n % WIN == WIN - 1) begin
                done_rec.ave = win_count_t'(win_cnt < 9999 ? win_cnt : 9999);
                if (done_rec.ave < exp_worst) begin
                    exp_worst = done_rec.ave;
                end
                done_rec.worst      = exp_worst;
                done_rec.last_cycle = cyc_n;
                pending.push_back(done_rec);
                win_cnt = 0;
            end
            if (update) begin
                if (pending.size() == 0) begin
                    $display("Update pulse at %0t ns with no finished window", $time);
                    stop_run();
                end
                head = pending.pop_front();
                check_latency("update", cyc_n - head.last_cycle, UPDATE_LAT);
                check_bcd("fave", fave, to_bcd(head.ave));
                check_bcd("fworst", fworst, to_bcd(head.worst));
            end else if (pending.size() != 0 &&
                         cyc_n - pending[0].last_cycle > UPDATE_LAT) begin
                $display("Update pulse missing after window ending at cycle %0d",
                         pending[0].last_cycle);
                stop_run();
            end
            cyc_n++;
        end
    end

    initial begin
        int    cnt;
        int    len;
        int    runs;
        int    cycles;
        int    i;
        int    cen_cnt [4];
        int    prc_cnt [4];
        busy_t val;
        bcd_t  pre;
        bcd_t  low;
        reset = 1'b1;
        busy  = '0;
        void'($urandom(SEED));
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        // Outputs straight after reset
        @(negedge clk);
        for (i = 0; i < 4; i++) begin
            check_bit({"prc_", chan_name(i)}, prc_vec[i], 1'b0);
            check_bit({"cen_", chan_name(i)}, cen_vec[i], 1'b0);
        end
        check_bit("update", update, 1'b0);
        check_bcd("fave", fave, '0);
        check_bcd("fworst", fworst, '0);

        // Main rate over 800 cycles on a free bus
        cnt = 0;
        repeat (800) begin
            @(negedge clk);
            if (cen_vec[0]) cnt++;
        end
        check_count("cen_main count", win_count_t'(cnt),
                    win_count_t'((800 * int'(CH_NUM[0])) / int'(CH_DEN[0])));

        // Random busy runs with about 30 percent held
        runs   = 0;
        cycles = 0;
        while (cycles < 1000 && runs < 2000) begin
            len = $urandom_range(12, 0);
            if ($urandom_range(99, 0) < 30) begin
                val = busy_t'($urandom_range(7, 1));
            end else begin
                val = '0;
            end
            repeat (len) begin
                @(posedge clk);
                busy <= val;
            end
            cycles += len;
            runs++;
        end

        // Long stall fills the credit before the payback is counted
        repeat (40) begin
            @(posedge clk);
            busy <= '1;
        end
        for (i = 0; i < 4; i++) begin
            cen_cnt[i] = 0;
            prc_cnt[i] = 0;
        end
        repeat (64) begin
            @(posedge clk);
            busy <= '0;
            @(negedge clk);
            for (i = 0; i < 4; i++) begin
                cen_cnt[i] += int'(cen_vec[i]);
                prc_cnt[i] += int'(prc_vec[i]);
            end
        end
        for (i = 0; i < 4; i++) begin
            check_count({"extra cen_", chan_name(i)}, win_count_t'(cen_cnt[i] - prc_cnt[i]),
                        win_count_t'(CREDIT_MAX));
        end
        wait_update();

        // A held window lowers fworst and later free windows leave it
        pre = fworst;
        repeat (400) begin
            @(posedge clk);
            busy <= 3'b001;
        end
        repeat (250) begin
            @(posedge clk);
            busy <= '0;
        end
        wait_update();
        low = fworst;
        if (!(low < pre)) begin
            $display("Busy window did not lower fworst, %h before and %h after", pre, low);
            stop_run();
        end
        repeat (600) @(posedge clk);
        wait_update();
        check_bcd("fworst", fworst, low);

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/cen_loop.sv ====
// CPU clock enable loop
`default_nettype none
`timescale 1ns/100ps

module cen_loop
    import cen_pkg::*;
#(
    parameter frac_t MAIN_NUM   = 10'd3,
    parameter frac_t MAIN_DEN   = 10'd64,
    parameter frac_t SUB_NUM    = 10'd3,
    parameter frac_t SUB_DEN    = 10'd64,
    parameter frac_t SND_NUM    = 10'd1,
    parameter frac_t SND_DEN    = 10'd32,
    parameter frac_t MCU_NUM    = 10'd1,
    parameter frac_t MCU_DEN    = 10'd16,
    parameter int    WIN_CYCLES = 2000
) (
    input  logic  clk,
    input  logic  reset,
    input  busy_t busy,

    output logic  prc_main,
    output logic  prc_sub,
    output logic  prc_snd,
    output logic  prc_mcu,
    output logic  cen_main,
    output logic  cen_sub,
    output logic  cen_snd,
    output logic  cen_mcu,

    output bcd_t  fave,
    output bcd_t  fworst,
    output logic  update
);

    logic       stall;
    win_count_t ave;
    win_count_t worst;
    logic       win_done;

    // Any master waiting on memory holds every CPU
    assign stall = |busy;

    cen_frac #(.NUM(MAIN_NUM), .DEN(MAIN_DEN)) u_main (
        .clk    ( clk       ),
        .reset  ( reset     ),
        .stall  ( stall     ),
        .prc    ( prc_main  ),
        .cen    ( cen_main  )
    );

    cen_frac #(.NUM(SUB_NUM), .DEN(SUB_DEN)) u_sub (
        .clk    ( clk       ),
        .reset  ( reset     ),
        .stall  ( stall     ),
        .prc    ( prc_sub   ),
        .cen    ( cen_sub   )
    );

    cen_frac #(.NUM(SND_NUM), .DEN(SND_DEN)) u_snd (
        .clk    ( clk       ),
        .reset  ( reset     ),
        .stall  ( stall     ),
        .prc    ( prc_snd   ),
        .cen    ( cen_snd   )
    );

    cen_frac #(.NUM(MCU_NUM), .DEN(MCU_DEN)) u_mcu (
        .clk    ( clk       ),
        .reset  ( reset     ),
        .stall  ( stall     ),
        .prc    ( prc_mcu   ),
        .cen    ( cen_mcu   )
    );

    // Measured main CPU rate
    freq_window #(.WIN_CYCLES(WIN_CYCLES)) u_win (
        .clk      ( clk       ),
        .reset    ( reset     ),
        .cen      ( cen_main  ),
        .ave      ( ave       ),
        .worst    ( worst     ),
        .win_done ( win_done  )
    );

    bcd_fsm u_bcd (
        .clk    ( clk       ),
        .reset  ( reset     ),
        .start  ( win_done  ),
        .ave    ( ave       ),
        .worst  ( worst     ),
        .fave   ( fave      ),
        .fworst ( fworst    ),
        .update ( update    )
    );

endmodule

`default_nettype wire

// ==== src/bcd_fsm.sv ====
// Window count to BCD converter
`default_nettype none
`timescale 1ns/100ps

module bcd_fsm
    import cen_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  win_count_t ave,
    input  win_count_t worst,
    output bcd_t       fave,
    output bcd_t       fworst,
    output logic       update
);

    // Double dabble register, digits shift in from the binary side
    typedef struct packed {
        bcd_t       digits;
        win_count_t bin;
    } dd_t;

    localparam int STEPS = $bits(win_count_t);

    bcd_state_t state;
    dd_t        dd;
    dd_t        dd_step;
    bcd_t       ave_bcd;
    logic [3:0] step;
    logic       last_step;

    // Add 3 to every digit of 5 or more before the shift
    function automatic bcd_t adjust(input bcd_t d);
        bcd_t r;
        int   i;
        r = d;
        for (i = 0; i < 4; i++) begin
            if (r[i*4 +: 4] >= 4'd5) begin
                r[i*4 +: 4] = r[i*4 +: 4] + 4'd3;
            end
        end
        return r;
    endfunction

    function automatic logic digits_ok(input bcd_t d);
        return d[3:0] <= 4'd9 && d[7:4] <= 4'd9 && d[11:8] <= 4'd9 && d[15:12] <= 4'd9;
    endfunction

    assign dd_step   = {adjust(dd.digits), dd.bin} << 1;
    assign last_step = step == 4'(STEPS - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= IDLE;
            step   <= '0;
            fave   <= '0;
            fworst <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) state <= LOAD_AVE;
                end
                LOAD_AVE: begin
                    step  <= '0;
                    state <= SHIFT_AVE;
                end
                SHIFT_AVE: begin
                    step <= step + 1'b1;
                    if (last_step) state <= LOAD_WORST;
                end
                LOAD_WORST: begin
                    step  <= '0;
                    state <= SHIFT_WORST;
                end
                SHIFT_WORST: begin
                    step <= step + 1'b1;
                    if (last_step) begin
                        // Both results change on the same edge
                        fave   <= ave_bcd;
                        fworst <= dd_step.digits;
                        state  <= DONE;
                    end
                end
                DONE: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Shift datapath
    always_ff @(posedge clk) begin
        case (state)
            LOAD_AVE: dd <= '{digits: '0, bin: ave};
            LOAD_WORST: begin
                ave_bcd <= dd.digits;
                dd      <= '{digits: '0, bin: worst};
            end
            SHIFT_AVE, SHIFT_WORST: dd <= dd_step;
            default: dd <= dd;
        endcase
    end

    assign update = state == DONE;

    // A new window must not interrupt a conversion
    a_start_idle: assert property (
        @(posedge clk) disable iff (reset)
        start |-> state == IDLE
    );

    a_digits_valid: assert property (
        @(posedge clk) disable iff (reset)
        update |-> digits_ok(fave) && digits_ok(fworst)
    );

endmodule

`default_nettype wire

// ==== src/freq_window.sv ====
// Main CPU enable rate window
`default_nettype none
`timescale 1ns/100ps

module freq_window
    import cen_pkg::*;
#(
    parameter int WIN_CYCLES = 2000
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       cen,
    output win_count_t ave,
    output win_count_t worst,
    output logic       win_done
);

    localparam int CW = $clog2(WIN_CYCLES);

    logic [CW-1:0] cyc;
    logic          last;
    win_count_t    count;
    win_count_t    count_next;

    // Window must outlast one BCD conversion
    if (WIN_CYCLES < 64) begin : g_win_check
        $error("WIN_CYCLES shorter than the BCD conversion");
    end

    assign last = cyc == CW'(WIN_CYCLES - 1);

    // Saturating enable count including this cycle
    always_comb begin
        if (cen && count != WIN_COUNT_MAX) begin
            count_next = count + 1'b1;
        end else begin
            count_next = count;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cyc   <= '0;
            count <= '0;
            ave   <= '0;
            worst <= WIN_COUNT_MAX;
        end else if (last) begin
            cyc   <= '0;
            count <= '0;
            ave   <= count_next;
            // Slowest window since reset
            if (count_next < worst) begin
                worst <= count_next;
            end
        end else begin
            cyc   <= cyc + 1'b1;
            count <= count_next;
        end
    end

    // High on the window's last cycle while results land on the next edge
    assign win_done = last;

    a_done_single: assert property (
        @(posedge clk) disable iff (reset)
        win_done |=> !win_done
    );

endmodule

`default_nettype wire

// ==== src/cen_frac.sv ====
// Fractional CPU clock enable
`default_nettype none
`timescale 1ns/100ps

module cen_frac
    import cen_pkg::*;
#(
    parameter frac_t NUM = 10'd1,
    parameter frac_t DEN = 10'd2
) (
    input  logic clk,
    input  logic reset,
    input  logic stall,
    output logic prc,
    output logic cen
);

    // One extra bit so acc + NUM cannot wrap
    logic [$bits(frac_t):0] sum;
    logic                   due;
    frac_t                  acc;
    frac_t                  acc_next;
    credit_t                credit;

    if (DEN == '0 || NUM > DEN) begin : g_ratio_check
        $error("cen_frac needs 0 < NUM <= DEN");
    end

    assign sum = {1'b0, acc} + {1'b0, NUM};
    assign due = sum >= {1'b0, DEN};

    always_comb begin
        if (due) begin
            acc_next = frac_t'(sum - {1'b0, DEN});
        end else begin
            acc_next = frac_t'(sum);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            acc    <= '0;
            prc    <= 1'b0;
            credit <= '0;
        end else begin
            acc <= acc_next;
            // prc marks the enable that fell due last cycle
            prc <= due;
            if (stall) begin
                // Bank the due enable unless the credit is full
                if (prc && credit != CREDIT_MAX) begin
                    credit <= credit + 1'b1;
                end
            end else if (!prc && credit != '0) begin
                // Pay one owed enable back in a free slot
                credit <= credit - 1'b1;
            end
        end
    end

    // Direct enable on a due cycle or else one from credit
    assign cen = !stall && (prc || credit != '0);

    // CPU must not be clocked while its bus is busy
    a_no_cen_on_stall: assert property (
        @(posedge clk) disable iff (reset)
        stall |-> !cen
    );

    // Full credit stays full through a stall without wrapping
    a_credit_sat: assert property (
        @(posedge clk) disable iff (reset)
        stall && credit == CREDIT_MAX |=> credit == CREDIT_MAX
    );

endmodule

`default_nettype wire

// ==== src/cen_pkg.sv ====
// CPU clock enable types
`default_nettype none

package cen_pkg;

    // Numerator, denominator and accumulator of a fractional enable
    typedef logic [9:0] frac_t;

    // Enables a stalled channel still owes
    typedef logic [2:0] credit_t;

    // Enables falling due beyond this are dropped
    localparam credit_t CREDIT_MAX = 3'd7;

    // Main CPU enables seen in one window
    typedef logic [13:0] win_count_t;

    // Counter ceiling, four BCD digits
    localparam win_count_t WIN_COUNT_MAX = 14'd9999;

    // Four BCD digits, thousands in [15:12]
    typedef logic [15:0] bcd_t;

    // Bus masters: [0] main bus, [1] MCU, [2] sound
    typedef logic [2:0] busy_t;

    // Binary to BCD converter
    typedef enum logic [2:0] {
        IDLE,
        LOAD_AVE,
        SHIFT_AVE,
        LOAD_WORST,
        SHIFT_WORST,
        DONE
    } bcd_state_t;

endpackage

`default_nettype wire
